//--- board_audio.f
src/board_pkg.sv
src/slow_clk_gen.sv
src/i2s_mic_receiver.sv
src/i2s_audio_out.sv
src/lab_top.sv
src/seg7_sticky_latch.sv
src/board_top.sv
bench/tb_board_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_board_top -f board_audio.f -o tb_board_top &&
./obj_dir/tb_board_top ||
exit 1

//--- bench/tb_board_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_board_top
    import board_pkg::*;
();

    localparam int clk_mhz     = 1;
    localparam int slow_clk_hz = 1000;
    localparam int w_key       = 4;
    localparam int w_sw        = 8;
    localparam int w_led       = 9;
    localparam int sck_half    = 2;
    localparam int bclk_half   = 2;
    localparam int scan_div    = 4;
    localparam int tick_period = clk_mhz * 1000000 / slow_clk_hz;  // clk cycles per led[0] toggle

    typedef enum int {ws_fall, sck_fall, lrclk_fall, bclk_rise, led0_toggle} edge_kind_t;

    logic               clk;
    logic               rst;
    logic [w_key-1:0]   key;
    logic [w_sw-1:0]    sw;
    logic [w_led-1:0]   led;
    logic [6:0]         hex0;
    logic [6:0]         hex1;
    logic [6:0]         hex2;
    logic [6:0]         hex3;
    logic [w_digit-1:0] dp_led;
    logic               mic_sd;
    mic_pins_t          mic;
    dac_pins_t          dac;

    logic               ws_q;               // Pin levels one clk back
    logic               sck_q;
    logic               lrclk_q;
    logic               bclk_q;
    logic               led0_q;
    logic [w_mic-1:0]   mic_word;           // Sent by the mic model every frame
    int                 frames_sent;
    integer             seed;

    board_top
    #(
        .clk_mhz     (clk_mhz),
        .slow_clk_hz (slow_clk_hz),
        .w_key       (w_key),
        .w_sw        (w_sw),
        .w_led       (w_led),
        .sck_half    (sck_half),
        .bclk_half   (bclk_half),
        .scan_div    (scan_div)
    )
    board_top_i
    (
        .clk    (clk),
        .rst    (rst),
        .key    (key),
        .sw     (sw),
        .led    (led),
        .hex0   (hex0),
        .hex1   (hex1),
        .hex2   (hex2),
        .hex3   (hex3),
        .dp_led (dp_led),
        .mic_sd (mic_sd),
        .mic    (mic),
        .dac    (dac)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    always @(posedge clk)
    begin
        ws_q    <= mic.ws;
        sck_q   <= mic.sck;
        lrclk_q <= dac.lrclk;
        bclk_q  <= dac.bclk;
        led0_q  <= led[0];
    end

    // ------------------------------------------------
    // Failure reporting and compare tasks

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic compare_hex(input int idx, input logic [6:0] got, input logic [6:0] exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch hex%0d: got %h expected %h", idx, got, exp));
    endtask

    task automatic compare_dp(input logic [w_digit-1:0] got, input logic [w_digit-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch dp_led: got %h expected %h", got, exp));
    endtask

    task automatic compare_sound(input logic [w_sound-1:0] got, input logic [w_sound-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch dac left word: got %h expected %h", got, exp));
    endtask

    task automatic compare_led(input logic [w_led-1:0] got, input logic [w_led-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch led: got %h expected %h", got, exp));
    endtask

    task automatic compare_mic(input mic_pins_t got, input mic_pins_t exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch mic pins: got %h expected %h", got, exp));
    endtask

    task automatic compare_dac(input dac_pins_t got, input dac_pins_t exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch dac pins: got %h expected %h", got, exp));
    endtask

    task automatic compare_mclk(input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch dac.mclk: got %h expected %h", got, exp));
    endtask

    task automatic compare_period(input int got, input int exp);
        if (got != exp)
            abort_run($sformatf("Mismatch led[0] toggle period: got %h expected %h", got, exp));
    endtask

    // ------------------------------------------------
    // Reference rules

    function automatic logic [6:0] segments_on(input logic [3:0] nibble);   // gfedcba
        case (nibble)
            4'h0:    return 7'h3f;
            4'h1:    return 7'h06;
            4'h2:    return 7'h5b;
            4'h3:    return 7'h4f;
            4'h4:    return 7'h66;
            4'h5:    return 7'h6d;
            4'h6:    return 7'h7d;
            4'h7:    return 7'h07;
            4'h8:    return 7'h7f;
            4'h9:    return 7'h6f;
            4'ha:    return 7'h77;
            4'hb:    return 7'h7c;
            4'hc:    return 7'h39;
            4'hd:    return 7'h5e;
            4'he:    return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    function automatic logic [w_sound-1:0] expected_sound(input logic [w_mic-1:0] value,
                                                         input logic [2:0]       shift);
        logic [w_sound-1:0] top;
        top = value[w_mic-1:w_mic-w_sound]; // Bits 23..8 of the sample
        for (int i = 0; i < int'(shift); i++)
            top = {top[w_sound-1], top[w_sound-1:1]};   // Sign bit fills in from the left
        return top;
    endfunction

    function automatic logic [w_mic-1:0] random_sample();
        logic [31:0] r;
        r = $random(seed);
        return r[w_mic-1:0];
    endfunction

    // ------------------------------------------------
    // Edge waits on the pins

    function automatic logic edge_seen(input edge_kind_t kind);
        case (kind)
            ws_fall:    return ws_q & ~mic.ws;
            sck_fall:   return sck_q & ~mic.sck;
            lrclk_fall: return lrclk_q & ~dac.lrclk;
            bclk_rise:  return ~bclk_q & dac.bclk;
            default:    return led0_q ^ led[0];
        endcase
    endfunction

    function automatic string edge_text(input edge_kind_t kind);
        case (kind)
            ws_fall:    return "the microphone word select to fall";
            sck_fall:   return "the microphone bit clock to fall";
            lrclk_fall: return "the DAC channel clock to fall";
            bclk_rise:  return "the DAC bit clock to rise";
            default:    return "the heartbeat LED to toggle";
        endcase
    endfunction

    task automatic wait_edge(input edge_kind_t kind, input int limit, output int cycles);
        cycles = 0;
        do
        begin
            if (cycles == limit)
                abort_run($sformatf("Timed out after %0d cycles waiting for %s",
                                    limit, edge_text(kind)));
            @(posedge clk);
            cycles++;
        end
        while (edge_seen(kind) !== 1'b1);
    endtask

    // ------------------------------------------------
    // Microphone model and DAC decoder

    task automatic mic_model();
        logic [w_mic-1:0] word;
        int               n;
        forever
        begin
            wait_edge(ws_fall, 600, n);     // Left slot begins with a dummy sck
            word = mic_word;
            for (int i = w_mic - 1; i >= 0; i--)
            begin
                wait_edge(sck_fall, 4 * sck_half, n);
                mic_sd <= word[i];          // MSB first
            end
            wait_edge(sck_fall, 4 * sck_half, n);
            mic_sd      <= 1'b0;
            frames_sent <= frames_sent + 1;
        end
    endtask

    task automatic mic_send(input logic [w_mic-1:0] value);
        int start;
        int n;
        mic_word = value;
        start    = frames_sent;
        n        = 0;
        while (frames_sent < start + 2)     // Second frame surely carries the new word
        begin
            if (n == 1200)
                abort_run("Microphone model finished no frame with the new sample in time");
            @(posedge clk);
            n++;
        end
    endtask

    task automatic dac_read_left(output logic [w_sound-1:0] word);
        int n;
        word = '0;
        wait_edge(lrclk_fall, 8 * bclk_half * w_sound, n);
        for (int i = 0; i < w_sound; i++)
        begin
            wait_edge(bclk_rise, 4 * bclk_half, n);
            word = {word[w_sound-2:0], dac.sdata};
        end
    endtask

    task automatic check_display(input logic [w_mic-1:0] value);
        logic [w_sound-1:0] top;
        logic [w_digit-1:0] dp_exp;
        top               = value[w_mic-1 -: w_sound];
        dp_exp            = '0;
        dp_exp[w_digit-1] = top[w_sound-1]; // Sign on the top digit
        repeat (2 * w_digit * scan_div) @(posedge clk);
        compare_hex(0, hex0, ~segments_on(top[3:0]));
        compare_hex(1, hex1, ~segments_on(top[7:4]));
        compare_hex(2, hex2, ~segments_on(top[11:8]));
        compare_hex(3, hex3, ~segments_on(top[15:12]));
        compare_dp(dp_led, dp_exp);
    endtask

    task automatic expect_idle_outputs();
        compare_hex(0, hex0, 7'h7f);
        compare_hex(1, hex1, 7'h7f);
        compare_hex(2, hex2, 7'h7f);
        compare_hex(3, hex3, 7'h7f);
        compare_dp(dp_led, '0);
        compare_led(led, '0);
        compare_mic(mic, '0);
        compare_dac(dac, '0);
    endtask

    // ------------------------------------------------
    // Directed tests

    task automatic reset_sequence();
        repeat (3) @(posedge clk);
        expect_idle_outputs();
        repeat (2) @(posedge clk);
        rst <= 1'b0;                        // Five cycles in reset
        @(posedge clk);
        expect_idle_outputs();
        for (int k = 1; k <= 4; k++)
        begin
            @(posedge clk);
            compare_mclk(dac.mclk, k[0]);   // Toggles every clk from low
        end
    endtask

    task automatic capture_display();
        logic [w_mic-1:0] value;
        value = random_sample();
        mic_send(value);
        check_display(value);
    endtask

    task automatic attenuated_loopback();
        logic [2:0]         shifts [3];
        logic [w_mic-1:0]   value;
        logic [w_sound-1:0] word;
        shifts = '{3'd0, 3'd3, 3'd7};
        for (int i = 0; i < 3; i++)
        begin
            value = random_sample();
            if (i == 2)
                value[w_mic-1] = 1'b1;      // Negative so the sign fill shows
            sw <= w_sw'(shifts[i]);
            mic_send(value);
            dac_read_left(word);
            dac_read_left(word);            // Second whole word after the strobe
            compare_sound(word, expected_sound(value, shifts[i]));
        end
    endtask

    task automatic mute_playback();
        logic [w_mic-1:0]   value;
        logic [w_sound-1:0] word;
        value          = random_sample();
        value[w_mic-2] = 1'b1;              // Nonzero after attenuation
        sw <= w_sw'(2);
        mic_send(value);
        key <= w_key'(1);
        dac_read_left(word);
        dac_read_left(word);
        compare_sound(word, '0);
        key <= '0;
        @(posedge clk);                     // Release lands before the next slot latch
        dac_read_left(word);
        compare_sound(word, expected_sound(value, 3'd2));
    endtask

    task automatic heartbeat_and_switches();
        int n;
        sw <= 8'ha5;
        repeat (2) @(posedge clk);
        compare_led({led[w_led-1:1], 1'b0}, {8'ha5, 1'b0});
        wait_edge(led0_toggle, tick_period + 100, n);
        for (int i = 0; i < 2; i++)
        begin
            wait_edge(led0_toggle, tick_period + 100, n);
            compare_period(n, tick_period);
        end
    endtask

    task automatic overwrite_sample();
        logic [w_mic-1:0]   first;
        logic [w_sound-1:0] word;
        logic [w_mic-1:0]   second;
        first  = random_sample();
        second = first ^ 24'hffff00;        // Every shown nibble differs
        sw <= w_sw'(1);
        mic_send(first);
        mic_send(second);
        check_display(second);
        dac_read_left(word);
        dac_read_left(word);
        compare_sound(word, expected_sound(second, 3'd1));
    endtask

    initial
    begin
        seed         = 32'hc715;
        mic_word     = '0;
        rst         <= 1'b1;
        key         <= '0;
        sw          <= '0;
        mic_sd      <= 1'b0;
        frames_sent <= 0;
        reset_sequence();
        fork
            mic_model();
        join_none
        capture_display();
        attenuated_loopback();
        mute_playback();
        heartbeat_and_switches();
        overwrite_sample();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/board_top.sv
`timescale 1ns/100ps
`default_nettype none

module board_top
    import board_pkg::*;
#(
    parameter int clk_mhz     = 50,
    parameter int slow_clk_hz = 1,
    parameter int w_key       = 4,
    parameter int w_sw        = 8,
    parameter int w_led       = 9,
    parameter int sck_half    = 10,         // 2.5 MHz sck at 50 MHz
    parameter int bclk_half   = 16,
    parameter int scan_div    = clk_mhz * 1000
)
(
    input  wire                clk,
    input  wire                rst,
    input  wire  [w_key-1:0]   key,         // Active high
    input  wire  [w_sw-1:0]    sw,
    output logic [w_led-1:0]   led,
    output logic [6:0]         hex0,        // Active low
    output logic [6:0]         hex1,
    output logic [6:0]         hex2,
    output logic [6:0]         hex3,
    output logic [w_digit-1:0] dp_led,      // Decimal points on LEDs
    input  wire                mic_sd,
    output mic_pins_t          mic,
    output dac_pins_t          dac
);

    logic               slow_tick;
    logic [w_mic-1:0]   mic_value;
    logic               mic_strobe;
    logic [w_sound-1:0] sound;
    seg7_bus_t          seg;

    // ------------------------------------------------
    // Heartbeat

    slow_clk_gen #(.fast_clk_mhz(clk_mhz), .slow_clk_hz(slow_clk_hz)) slow_clk_gen_i
    (
        .clk       (clk),
        .rst       (rst),
        .slow_tick (slow_tick)
    );

    // ------------------------------------------------
    // Audio in and out

    i2s_mic_receiver #(.sck_half(sck_half)) i2s_mic_receiver_i
    (
        .clk    (clk),
        .rst    (rst),
        .sd     (mic_sd),
        .pins   (mic),
        .value  (mic_value),
        .strobe (mic_strobe)
    );

    i2s_audio_out #(.clk_mhz(clk_mhz), .bclk_half(bclk_half)) i2s_audio_out_i
    (
        .clk     (clk),
        .rst     (rst),
        .data_in (sound),
        .pins    (dac)
    );

    // ------------------------------------------------
    // Core and display

    lab_top
    #(
        .clk_mhz  (clk_mhz),
        .w_key    (w_key),
        .w_sw     (w_sw),
        .w_led    (w_led),
        .scan_div (scan_div)
    )
    lab_top_i
    (
        .clk        (clk),
        .rst        (rst),
        .slow_tick  (slow_tick),
        .key        (key),
        .sw         (sw),
        .mic_value  (mic_value),
        .mic_strobe (mic_strobe),
        .led        (led),
        .seg        (seg),
        .sound      (sound)
    );

    seg7_sticky_latch seg7_sticky_latch_i
    (
        .clk  (clk),
        .rst  (rst),
        .seg  (seg),
        .hex0 (hex0),
        .hex1 (hex1),
        .hex2 (hex2),
        .hex3 (hex3),
        .dp   (dp_led)
    );

endmodule

`default_nettype wire

//--- src/seg7_sticky_latch.sv
`timescale 1ns/100ps
`default_nettype none

module seg7_sticky_latch
    import board_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire seg7_bus_t     seg,         // Scanned bus from the core
    output logic [6:0]         hex0,        // Active low, a in bit 0
    output logic [6:0]         hex1,
    output logic [6:0]         hex2,
    output logic [6:0]         hex3,
    output logic [w_digit-1:0] dp           // Active high
);

    logic [7:0] hgfedcba;                   // Bit order of the HEX pins
    logic [6:0] hex_r [w_digit];            // Last pattern seen per digit

    assign hgfedcba = {<<{seg.abcdefgh}};

    // ------------------------------------------------
    // Hold each digit between its scan slots

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < w_digit; i++)
                hex_r[i] <= '1;             // All segments off
            dp <= '0;
        end
        else
        begin
            for (int i = 0; i < w_digit; i++)
            begin
                if (seg.digit[i])
                begin
                    hex_r[i] <= ~hgfedcba[6:0];
                    dp[i]    <=  hgfedcba[7];
                end
            end
        end
    end

    assign hex0 = hex_r[0];
    assign hex1 = hex_r[1];
    assign hex2 = hex_r[2];
    assign hex3 = hex_r[3];

endmodule

`default_nettype wire

//--- src/lab_top.sv
`timescale 1ns/100ps
`default_nettype none

module lab_top
    import board_pkg::*;
#(
    parameter int clk_mhz  = 50,
    parameter int w_key    = 4,
    parameter int w_sw     = 8,
    parameter int w_led    = 9,
    parameter int scan_div = clk_mhz * 1000 // About 1 kHz per digit
)
(
    input  wire                clk,
    input  wire                rst,
    input  wire                slow_tick,
    input  wire  [w_key-1:0]   key,         // key[0] mutes
    input  wire  [w_sw-1:0]    sw,          // sw[2:0] attenuation
    input  wire  [w_mic-1:0]   mic_value,
    input  wire                mic_strobe,
    output logic [w_led-1:0]   led,
    output seg7_bus_t          seg,
    output logic [w_sound-1:0] sound
);

    localparam int w_scan = scan_div > 1 ? $clog2(scan_div) : 1;
    localparam int w_idx  = w_digit > 1 ? $clog2(w_digit) : 1;

    logic signed [w_sound-1:0] sample;      // Top bits of latest mic word
    logic signed [w_sound-1:0] scaled;
    logic        [w_scan-1:0]  scan_cnt;
    logic        [w_idx-1:0]   digit_idx;   // Digit on the bus now
    logic        [3:0]         nibble;
    logic                      neg_dp;      // Sign shown on top digit

    // ------------------------------------------------
    // Audio path

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            sample <= '0;
        else if (mic_strobe)
            sample <= mic_value[w_mic-1 -: w_sound];    // Newer sample overwrites
    end

    assign scaled = sample >>> sw[2:0];     // Arithmetic, keeps sign
    assign sound  = key[0] ? '0 : scaled;

    // ------------------------------------------------
    // Display scan

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end
        else if (scan_cnt == w_scan'(scan_div - 1))
        begin
            scan_cnt <= '0;
            if (digit_idx == w_idx'(w_digit - 1))
                digit_idx <= '0;
            else
                digit_idx <= digit_idx + 1'b1;
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    assign nibble = sample[{digit_idx, 2'b00} +: 4];    // Digit 0 is bits 3..0
    assign neg_dp = (digit_idx == w_idx'(w_digit - 1)) && sample[w_sound-1];

    assign seg.abcdefgh = hex_to_abcdefgh(nibble) | {7'b0, neg_dp};
    assign seg.digit    = w_digit'(1) << digit_idx;

    // ------------------------------------------------
    // LEDs

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            led <= '0;
        else
        begin
            if (slow_tick)
                led[0] <= ~led[0];          // Heartbeat
            led[w_led-1:1] <= (w_led - 1)'(sw);
        end
    end

endmodule

`default_nettype wire

//--- src/i2s_audio_out.sv
`timescale 1ns/100ps
`default_nettype none

module i2s_audio_out
    import board_pkg::*;
#(
    parameter int clk_mhz   = 50,
    parameter int bclk_half = (clk_mhz / 3 > 0) ? clk_mhz / 3 : 1   // Near 48 kHz frames
)
(
    input  wire               clk,
    input  wire               rst,
    input  wire [w_sound-1:0] data_in,      // Sampled at each slot start
    output dac_pins_t         pins
);

    localparam int w_div = bclk_half > 1 ? $clog2(bclk_half) : 1;
    localparam int w_bit = $clog2(w_sound) + 1;     // Slot bits plus channel bit

    logic               mclk;
    logic               bclk;
    logic [w_div-1:0]   div_cnt;            // Counts mclk half periods
    logic               bclk_edge;
    logic               bclk_fall;
    logic [w_bit-1:0]   bit_cnt;            // MSB is lrclk
    logic               slot_end;           // Last bit of current slot
    logic [w_sound-1:0] shift;

    // ------------------------------------------------
    // Clocks

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            mclk <= 1'b0;
        else
            mclk <= ~mclk;                  // Toggles every clk
    end

    assign bclk_edge = (div_cnt == w_div'(bclk_half - 1));
    assign bclk_fall = bclk_edge & bclk;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            bclk    <= 1'b0;
        end
        else if (bclk_edge)
        begin
            div_cnt <= '0;
            bclk    <= ~bclk;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // ------------------------------------------------
    // Slot counter and serializer

    assign slot_end = &bit_cnt[w_bit-2:0];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bit_cnt <= '0;
            shift   <= '0;                  // Keeps sdata low
        end
        else if (bclk_fall)
        begin
            bit_cnt <= bit_cnt + 1'b1;      // lrclk moves on falling edge
            if (slot_end)
                shift <= data_in;           // Same word on both channels
            else
                shift <= {shift[w_sound-2:0], 1'b0};
        end
    end

    assign pins.mclk  = mclk;
    assign pins.bclk  = bclk;
    assign pins.lrclk = bit_cnt[w_bit-1];
    assign pins.sdata = shift[w_sound-1];   // MSB in first bclk of slot

endmodule

`default_nettype wire

//--- src/i2s_mic_receiver.sv
`timescale 1ns/100ps
`default_nettype none

module i2s_mic_receiver
    import board_pkg::*;
#(
    parameter int sck_half = 10             // clk cycles per sck half period
)
(
    input  wire              clk,
    input  wire              rst,
    input  wire              sd,            // Mic serial data
    output mic_pins_t        pins,
    output logic [w_mic-1:0] value,         // Held until next strobe
    output logic             strobe         // New left sample
);

    localparam int w_div = sck_half > 1 ? $clog2(sck_half) : 1;

    logic [w_div-1:0] div_cnt;
    logic             sck;
    logic             sck_edge;             // sck toggles this cycle
    logic             sck_rise;
    logic             sck_fall;
    logic [5:0]       bit_cnt;              // 32 sck per slot, MSB is ws
    logic             in_window;            // Bits 23..1 of left slot
    logic             last_bit;             // Bit 0 of left slot
    logic [w_mic-2:0] shift;                // Upper bits collected so far

    // ------------------------------------------------
    // sck and ws generation

    assign sck_edge = (div_cnt == w_div'(sck_half - 1));
    assign sck_rise = sck_edge & ~sck;
    assign sck_fall = sck_edge &  sck;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_edge)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bit_cnt <= '0;
        else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;      // ws moves on falling edge
    end

    assign pins.sck = sck;
    assign pins.ws  = bit_cnt[5];

    // ------------------------------------------------
    // Sample capture

    // First rising edge after ws falls is a dummy bit
    assign in_window = ~bit_cnt[5] && (bit_cnt >= 6'd1) && (bit_cnt < 6'(w_mic));
    assign last_bit  = ~bit_cnt[5] && (bit_cnt == 6'(w_mic));

    always_ff @(posedge clk)
    begin
        if (sck_rise && in_window)
            shift <= {shift[w_mic-3:0], sd};    // MSB arrives first
        if (sck_rise && last_bit)
            value <= {shift, sd};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            strobe <= 1'b0;
        else
            strobe <= sck_rise && last_bit;     // Valid with value
    end

endmodule

`default_nettype wire

//--- src/slow_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module slow_clk_gen
#(
    parameter int fast_clk_mhz = 50,
    parameter int slow_clk_hz  = 1
)
(
    input  wire  clk,
    input  wire  rst,
    output logic slow_tick
);

    localparam int period = fast_clk_mhz * 1000000 / slow_clk_hz;   // clk cycles per tick
    localparam int w_cnt  = period > 1 ? $clog2(period) : 1;

    logic [w_cnt-1:0] cnt;                  // Cycles left to next tick

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt       <= w_cnt'(period - 1);
            slow_tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt       <= w_cnt'(period - 1);  // Reload at terminal count
            slow_tick <= 1'b1;                // One cycle wide
        end
        else
        begin
            cnt       <= cnt - 1'b1;
            slow_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/board_pkg.sv
`default_nettype none

package board_pkg;

    // ------------------------------------------------
    // Widths

    localparam int w_digit = 4;             // Display digits
    localparam int w_mic   = 24;            // INMP441 sample width
    localparam int w_sound = 16;            // DAC sample width

    // ------------------------------------------------
    // Bundles

    typedef struct packed
    {
        logic [7:0]         abcdefgh;       // Active high, a in MSB, h is dp
        logic [w_digit-1:0] digit;          // One-hot digit enable
    } seg7_bus_t;

    typedef struct packed
    {
        logic sck;                          // Mic bit clock
        logic ws;                           // Word select, low for left
    } mic_pins_t;

    typedef struct packed
    {
        logic mclk;                         // Master clock, clk / 2
        logic bclk;                         // Bit clock
        logic lrclk;                        // Channel select, low for left
        logic sdata;                        // Serial data, MSB first
    } dac_pins_t;

    // Nibble to abcdefgh, h always cleared
    function automatic logic [7:0] hex_to_abcdefgh(input logic [3:0] nibble);
        logic [7:0] segs;
        case (nibble)
            4'h0:    segs = 8'b1111_1100;
            4'h1:    segs = 8'b0110_0000;
            4'h2:    segs = 8'b1101_1010;
            4'h3:    segs = 8'b1111_0010;
            4'h4:    segs = 8'b0110_0110;
            4'h5:    segs = 8'b1011_0110;
            4'h6:    segs = 8'b1011_1110;
            4'h7:    segs = 8'b1110_0000;
            4'h8:    segs = 8'b1111_1110;
            4'h9:    segs = 8'b1111_0110;
            4'ha:    segs = 8'b1110_1110;
            4'hb:    segs = 8'b0011_1110;   // Lower case b
            4'hc:    segs = 8'b1001_1100;
            4'hd:    segs = 8'b0111_1010;   // Lower case d
            4'he:    segs = 8'b1001_1110;
            default: segs = 8'b1000_1110;   // F
        endcase
        return segs;
    endfunction

endpackage

`default_nettype wire
